/* design/issue_pkg.sv */
package issue_pkg;

    // datapath and issue widths
    localparam int XLEN       = 32;
    localparam int NUM_SLOTS  = 2;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_RPORTS = 2 * NUM_SLOTS;

    // instruction word layout, low bit of each field
    localparam int OPC_W     = 4;
    localparam int OPC_LSB   = 28;
    localparam int RD_LSB    = 23;
    localparam int RS1_LSB   = 18;
    localparam int RS2_LSB   = 13;
    localparam int IMM_LSB   = 0;
    localparam int IMM_W     = 13;
    localparam int LUI_SHIFT = XLEN - IMM_W;

    // codes 9..15 are reserved and decode as nop
    typedef enum logic [OPC_W-1:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_SLT  = 4'h6,
        OP_ADDI = 4'h7,
        OP_LUI  = 4'h8
    } opcode_e;

    // decoder to dispatch
    typedef struct packed {
        logic                  valid;
        opcode_e               opcode;
        logic [REG_ADDR_W-1:0] rs1;
        logic                  rs1_en;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  rs2_en;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic [XLEN-1:0]       imm;
    } dec_slot_t;

    // dispatch to execute, operands already resolved
    typedef struct packed {
        logic                  valid;
        opcode_e               opcode;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic [XLEN-1:0]       op_a;
        logic [XLEN-1:0]       op_b;
    } ex_slot_t;

    // forwarded or written-back result
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } fwd_t;

endpackage

/* design/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  logic [issue_pkg::NUM_SLOTS-1:0][issue_pkg::XLEN-1:0] inst_i,
    input  logic [issue_pkg::NUM_SLOTS-1:0]                      inst_valid_i,
    output issue_pkg::dec_slot_t [issue_pkg::NUM_SLOTS-1:0]      dec_o
);

    for (genvar s = 0; s < issue_pkg::NUM_SLOTS; s++) begin : g_slot
        logic [issue_pkg::OPC_W-1:0]      code;
        logic [issue_pkg::IMM_W-1:0]      imm_raw;
        logic [issue_pkg::REG_ADDR_W-1:0] rd;
        issue_pkg::opcode_e               op;
        logic                             rs1_en;
        logic                             rs2_en;
        logic                             we;
        logic [issue_pkg::XLEN-1:0]       imm;

        assign code    = inst_i[s][issue_pkg::OPC_LSB +: issue_pkg::OPC_W];
        assign imm_raw = inst_i[s][issue_pkg::IMM_LSB +: issue_pkg::IMM_W];
        assign rd      = inst_i[s][issue_pkg::RD_LSB +: issue_pkg::REG_ADDR_W];

        // reserved codes fall back to nop
        always_comb begin
            case (code)
                issue_pkg::OP_ADD, issue_pkg::OP_SUB, issue_pkg::OP_AND,
                issue_pkg::OP_OR, issue_pkg::OP_XOR, issue_pkg::OP_SLT,
                issue_pkg::OP_ADDI, issue_pkg::OP_LUI: begin
                    op = issue_pkg::opcode_e'(code);
                end
                default: begin
                    op = issue_pkg::OP_NOP;
                end
            endcase
        end

        always_comb begin
            rs1_en = 1'b0;
            rs2_en = 1'b0;
            we     = 1'b1;
            imm    = {{(issue_pkg::XLEN - issue_pkg::IMM_W){imm_raw[issue_pkg::IMM_W-1]}},
                      imm_raw};
            case (op)
                issue_pkg::OP_NOP: begin
                    we = 1'b0;
                end
                issue_pkg::OP_ADDI: begin
                    rs1_en = 1'b1;
                end
                issue_pkg::OP_LUI: begin
                    imm = {imm_raw, {issue_pkg::LUI_SHIFT{1'b0}}};
                end
                default: begin
                    // register-register ops
                    rs1_en = 1'b1;
                    rs2_en = 1'b1;
                end
            endcase
        end

        // writes to x0 are dropped here
        assign dec_o[s] = '{
            valid:  inst_valid_i[s],
            opcode: op,
            rs1:    inst_i[s][issue_pkg::RS1_LSB +: issue_pkg::REG_ADDR_W],
            rs1_en: rs1_en,
            rs2:    inst_i[s][issue_pkg::RS2_LSB +: issue_pkg::REG_ADDR_W],
            rs2_en: rs2_en,
            rd:     rd,
            we:     we && (rd != '0),
            imm:    imm
        };
    end

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                                                       clk,
    input  logic [issue_pkg::NUM_RPORTS-1:0][issue_pkg::REG_ADDR_W-1:0] raddr_i,
    input  logic [issue_pkg::NUM_RPORTS-1:0]                           ren_i,
    output logic [issue_pkg::NUM_RPORTS-1:0][issue_pkg::XLEN-1:0]      rdata_o,
    input  issue_pkg::fwd_t [issue_pkg::NUM_SLOTS-1:0]                 wr_i
);

    // x0 has no storage
    logic [issue_pkg::XLEN-1:0] regs [1:31];

    // ascending slot order, so slot 1 wins a collision
    always_ff @(posedge clk) begin
        for (int s = 0; s < issue_pkg::NUM_SLOTS; s++) begin
            if (wr_i[s].we && wr_i[s].rd != '0) begin
                regs[wr_i[s].rd] <= wr_i[s].data;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < issue_pkg::NUM_RPORTS; p++) begin
            if (ren_i[p] && raddr_i[p] != '0) begin
                rdata_o[p] = regs[raddr_i[p]];
            end else begin
                rdata_o[p] = '0;
            end
        end
    end

endmodule

/* design/dual_dispatch.sv */
`timescale 1ns/1ps

module dual_dispatch (
    input  logic                                                     clk,
    input  logic                                                     rst_n_i,
    input  logic                                                     pause_i,
    input  logic                                                     flush_i,
    input  issue_pkg::dec_slot_t [issue_pkg::NUM_SLOTS-1:0]          dec_i,
    input  issue_pkg::fwd_t [issue_pkg::NUM_SLOTS-1:0]               ex_fwd_i,
    input  issue_pkg::fwd_t [issue_pkg::NUM_SLOTS-1:0]               wb_fwd_i,
    output logic [issue_pkg::NUM_RPORTS-1:0][issue_pkg::REG_ADDR_W-1:0] rf_raddr_o,
    output logic [issue_pkg::NUM_RPORTS-1:0]                         rf_ren_o,
    input  logic [issue_pkg::NUM_RPORTS-1:0][issue_pkg::XLEN-1:0]    rf_rdata_i,
    output logic [issue_pkg::NUM_SLOTS-1:0]                          issued_o,
    output issue_pkg::ex_slot_t [issue_pkg::NUM_SLOTS-1:0]           ex_o
);

    logic [issue_pkg::NUM_SLOTS-1:0]                 valid;
    logic                                            dep_10;
    logic                                            dual_ok;
    logic [issue_pkg::NUM_SLOTS-1:0]                 issue_en;
    issue_pkg::ex_slot_t [issue_pkg::NUM_SLOTS-1:0]  ex_d;
    issue_pkg::ex_slot_t [issue_pkg::NUM_SLOTS-1:0]  ex_q;

    // lowest priority first, later hits overwrite
    function automatic logic [issue_pkg::XLEN-1:0] resolve(
        input logic                                       en,
        input logic [issue_pkg::REG_ADDR_W-1:0]           rs,
        input logic [issue_pkg::XLEN-1:0]                 rf_data,
        input logic [issue_pkg::XLEN-1:0]                 imm,
        input issue_pkg::fwd_t [issue_pkg::NUM_SLOTS-1:0] ex_f,
        input issue_pkg::fwd_t [issue_pkg::NUM_SLOTS-1:0] wb_f
    );
        logic [issue_pkg::XLEN-1:0] val;
        val = rf_data;
        for (int i = 0; i < issue_pkg::NUM_SLOTS; i++) begin
            if (wb_f[i].we && wb_f[i].rd == rs) begin
                val = wb_f[i].data;
            end
        end
        for (int i = 0; i < issue_pkg::NUM_SLOTS; i++) begin
            if (ex_f[i].we && ex_f[i].rd == rs) begin
                val = ex_f[i].data;
            end
        end
        if (rs == '0) begin
            val = '0;
        end
        if (!en) begin
            val = imm;
        end
        return val;
    endfunction

    assign valid = {dec_i[1].valid, dec_i[0].valid};

    // slot 1 must wait if it reads what slot 0 writes
    assign dep_10 = dec_i[0].we && (dec_i[0].rd != '0) &&
                    ((dec_i[1].rs1_en && dec_i[1].rs1 == dec_i[0].rd) ||
                     (dec_i[1].rs2_en && dec_i[1].rs2 == dec_i[0].rd));
    assign dual_ok = (&valid) && !dep_10;

    always_comb begin
        if (!rst_n_i || flush_i || pause_i || !(|valid)) begin
            issue_en = 2'b00;
        end else if (dual_ok) begin
            issue_en = 2'b11;
        end else if (valid[0]) begin
            issue_en = 2'b01;
        end else begin
            issue_en = 2'b10;
        end
    end

    assign issued_o = issue_en;

    for (genvar s = 0; s < issue_pkg::NUM_SLOTS; s++) begin : g_slot
        // port 2s carries rs1, port 2s+1 carries rs2
        assign rf_raddr_o[2*s]   = dec_i[s].rs1;
        assign rf_ren_o[2*s]     = dec_i[s].rs1_en;
        assign rf_raddr_o[2*s+1] = dec_i[s].rs2;
        assign rf_ren_o[2*s+1]   = dec_i[s].rs2_en;

        assign ex_d[s] = '{
            valid:  dec_i[s].valid,
            opcode: dec_i[s].opcode,
            rd:     dec_i[s].rd,
            we:     dec_i[s].we,
            op_a:   resolve(dec_i[s].rs1_en, dec_i[s].rs1, rf_rdata_i[2*s],
                            dec_i[s].imm, ex_fwd_i, wb_fwd_i),
            op_b:   resolve(dec_i[s].rs2_en, dec_i[s].rs2, rf_rdata_i[2*s+1],
                            dec_i[s].imm, ex_fwd_i, wb_fwd_i)
        };

        // flush kills what sits in execute this cycle
        assign ex_o[s] = flush_i ? '0 : ex_q[s];
    end

    // non-issued slots become bubbles
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            ex_q <= '0;
        end else begin
            for (int s = 0; s < issue_pkg::NUM_SLOTS; s++) begin
                ex_q[s] <= issue_en[s] ? ex_d[s] : '0;
            end
        end
    end

    a_issue_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        (issued_o & ~valid) == '0);

    a_flush_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> !(ex_o[0].valid || ex_o[1].valid));

endmodule

/* design/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
    input  logic                                           clk,
    input  logic                                           rst_n_i,
    input  issue_pkg::ex_slot_t [issue_pkg::NUM_SLOTS-1:0] ex_i,
    output issue_pkg::fwd_t [issue_pkg::NUM_SLOTS-1:0]     ex_fwd_o,
    output issue_pkg::fwd_t [issue_pkg::NUM_SLOTS-1:0]     wb_o
);

    for (genvar s = 0; s < issue_pkg::NUM_SLOTS; s++) begin : g_alu
        logic [issue_pkg::XLEN-1:0] a;
        logic [issue_pkg::XLEN-1:0] b;
        logic [issue_pkg::XLEN-1:0] res;

        assign a = ex_i[s].op_a;
        assign b = ex_i[s].op_b;

        always_comb begin
            case (ex_i[s].opcode)
                issue_pkg::OP_ADD:  res = a + b;
                issue_pkg::OP_SUB:  res = a - b;
                issue_pkg::OP_AND:  res = a & b;
                issue_pkg::OP_OR:   res = a | b;
                issue_pkg::OP_XOR:  res = a ^ b;
                issue_pkg::OP_SLT: begin
                    res = {{(issue_pkg::XLEN - 1){1'b0}}, $signed(a) < $signed(b)};
                end
                // b already holds the immediate
                issue_pkg::OP_ADDI: res = a + b;
                issue_pkg::OP_LUI:  res = b;
                default:            res = '0;
            endcase
        end

        assign ex_fwd_o[s] = '{
            we:   ex_i[s].valid && ex_i[s].we,
            rd:   ex_i[s].rd,
            data: res
        };

        // decoder clears the write for nop, nothing downstream should see one
        a_nop_no_write: assert property (@(posedge clk) disable iff (!rst_n_i)
            (ex_i[s].valid && ex_i[s].opcode == issue_pkg::OP_NOP) |-> !ex_i[s].we);
    end

    // write-back stage
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_o <= '0;
        end else begin
            wb_o <= ex_fwd_o;
        end
    end

endmodule

/* design/issue_core.sv */
`timescale 1ns/1ps

module issue_core (
    input  logic                                                 clk,
    input  logic                                                 rst_n_i,
    input  logic                                                 pause_i,
    input  logic                                                 flush_i,
    input  logic [issue_pkg::NUM_SLOTS-1:0][issue_pkg::XLEN-1:0] inst_i,
    input  logic [issue_pkg::NUM_SLOTS-1:0]                      inst_valid_i,
    output logic [issue_pkg::NUM_SLOTS-1:0]                      issued_o,
    output issue_pkg::fwd_t [issue_pkg::NUM_SLOTS-1:0]           wb_o
);

    issue_pkg::dec_slot_t [issue_pkg::NUM_SLOTS-1:0]                 dec;
    issue_pkg::ex_slot_t [issue_pkg::NUM_SLOTS-1:0]                  ex;
    issue_pkg::fwd_t [issue_pkg::NUM_SLOTS-1:0]                      ex_fwd;
    logic [issue_pkg::NUM_RPORTS-1:0][issue_pkg::REG_ADDR_W-1:0]     rf_raddr;
    logic [issue_pkg::NUM_RPORTS-1:0]                                rf_ren;
    logic [issue_pkg::NUM_RPORTS-1:0][issue_pkg::XLEN-1:0]           rf_rdata;

    inst_decoder u_decoder (
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .dec_o        (dec)
    );

    dual_dispatch u_dispatch (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .pause_i    (pause_i),
        .flush_i    (flush_i),
        .dec_i      (dec),
        .ex_fwd_i   (ex_fwd),
        .wb_fwd_i   (wb_o),
        .rf_raddr_o (rf_raddr),
        .rf_ren_o   (rf_ren),
        .rf_rdata_i (rf_rdata),
        .issued_o   (issued_o),
        .ex_o       (ex)
    );

    // write-back results go straight into the register file
    reg_file u_reg_file (
        .clk     (clk),
        .raddr_i (rf_raddr),
        .ren_i   (rf_ren),
        .rdata_o (rf_rdata),
        .wr_i    (wb_o)
    );

    exec_unit u_exec (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .ex_i     (ex),
        .ex_fwd_o (ex_fwd),
        .wb_o     (wb_o)
    );

endmodule

/* sim/issue_core_tb.sv */
`timescale 1ns/1ps

module issue_core_tb;

    typedef struct packed {
        int unsigned cyc;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] old;
    } exp_t;

    localparam int N_INSTR = 31 + 8 + 6 + 12 + 6 + 8 + 400;

    logic                               clk;
    logic                               rst_n_i;
    logic                               pause_i;
    logic                               flush_i;
    logic [1:0][31:0]                   inst_i;
    logic [1:0]                         inst_valid_i;
    logic [1:0]                         issued_o;
    issue_pkg::fwd_t [1:0]              wb;
    logic [31:0]                        regs [32];
    exp_t                               exp_q [$];
    exp_t                               head;
    logic [31:0]                        prog [$];
    int unsigned                        cyc_cnt = 0;
    integer                             seed;

    issue_core u_dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pause_i      (pause_i),
        .flush_i      (flush_i),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .issued_o     (issued_o),
        .wb_o         (wb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    function automatic logic [31:0] enc(input logic [3:0] op, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2,
                                        input logic [12:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    // reserved codes act as nop
    function automatic logic [3:0] op_of(input logic [31:0] w);
        return (w[31:28] > 4'h8) ? 4'h0 : w[31:28];
    endfunction

    function automatic logic reads_a(input logic [31:0] w);
        return op_of(w) != issue_pkg::OP_NOP && op_of(w) != issue_pkg::OP_LUI;
    endfunction

    function automatic logic reads_b(input logic [31:0] w);
        return op_of(w) != issue_pkg::OP_NOP && op_of(w) < issue_pkg::OP_ADDI;
    endfunction

    function automatic logic writes(input logic [31:0] w);
        return op_of(w) != issue_pkg::OP_NOP && w[27:23] != 5'd0;
    endfunction

    task automatic model_issue(input logic [31:0] w);
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        imm = (op_of(w) == issue_pkg::OP_LUI) ? {w[12:0], 19'b0} : {{19{w[12]}}, w[12:0]};
        a = reads_a(w) ? regs[w[22:18]] : imm;
        b = reads_b(w) ? regs[w[17:13]] : imm;
        case (op_of(w))
            issue_pkg::OP_ADD, issue_pkg::OP_ADDI: res = a + b;
            issue_pkg::OP_SUB: res = a - b;
            issue_pkg::OP_AND: res = a & b;
            issue_pkg::OP_OR:  res = a | b;
            issue_pkg::OP_XOR: res = a ^ b;
            issue_pkg::OP_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:           res = b;
        endcase
        if (writes(w)) begin
            exp_q.push_back('{cyc: cyc_cnt + 2, rd: w[27:23], data: res, old: regs[w[27:23]]});
            regs[w[27:23]] = res;
        end
    endtask

    task automatic offer(input logic [31:0] w0, input logic v0, input logic [31:0] w1,
                         input logic v1, input logic pause, input logic flush,
                         output logic [1:0] iss);
        logic       dep;
        logic [1:0] exp_iss;
        exp_t       gone;
        @(negedge clk);
        inst_i       = {w1, w0};
        inst_valid_i = {v1, v0};
        pause_i      = pause;
        flush_i      = flush;
        #1;
        // results issued last cycle die in execute and leave the model
        while (flush && exp_q.size() != 0 && exp_q[$].cyc == cyc_cnt + 1) begin
            gone = exp_q.pop_back();
            regs[gone.rd] = gone.old;
        end
        dep = writes(w0) && ((reads_a(w1) && w1[22:18] == w0[27:23]) ||
                             (reads_b(w1) && w1[17:13] == w0[27:23]));
        if (pause || flush || !(v0 || v1)) begin
            exp_iss = 2'b00;
        end else if (v0 && v1 && !dep) begin
            exp_iss = 2'b11;
        end else begin
            exp_iss = v0 ? 2'b01 : 2'b10;
        end
        iss = issued_o;
        check(iss, exp_iss, "issued_o");
        if (iss[0]) begin
            model_issue(w0);
        end
        if (iss[1]) begin
            model_issue(w1);
        end
    endtask

    // results land two cycles after the last issue
    task automatic drain();
        logic [1:0] iss;
        repeat (2) begin
            offer(32'h0, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0, iss);
        end
    endtask

    // head of the program always goes into slot 0
    task automatic run_prog(input int pause_pct);
        logic [1:0] iss;
        logic       pause;
        while (prog.size() != 0) begin
            pause = (($random(seed) & 32'h7fff_ffff) % 100) < pause_pct;
            if (prog.size() > 1) begin
                offer(prog[0], 1'b1, prog[1], 1'b1, pause, 1'b0, iss);
            end else begin
                offer(prog[0], 1'b1, 32'h0, 1'b0, pause, 1'b0, iss);
            end
            if (iss[0]) begin
                void'(prog.pop_front());
            end
            if (iss[1]) begin
                void'(prog.pop_front());
            end
        end
        drain();
    endtask

    task automatic init_regs();
        for (int r = 1; r < 32; r++) begin
            prog.push_back(enc(issue_pkg::OP_ADDI, 5'(r), 5'd0, 5'd0, 13'($random(seed))));
        end
        run_prog(0);
    endtask

    task automatic pair_issue();
        logic [1:0] iss;
        for (int i = 0; i < 4; i++) begin
            offer(enc(issue_pkg::OP_ADD, 5'(i + 1), 5'(i + 16), 5'(i + 20), 13'h0), 1'b1,
                  enc(issue_pkg::OP_SLT, 5'(i + 8), 5'(i + 24), 5'(i + 17), 13'h0), 1'b1,
                  1'b0, 1'b0, iss);
            check(iss, 2'b11, "independent pair issue");
        end
        drain();
    endtask

    task automatic split_dependent();
        prog.push_back(enc(issue_pkg::OP_ADD, 5'd3, 5'd1, 5'd2, 13'h0));
        prog.push_back(enc(issue_pkg::OP_SUB, 5'd4, 5'd5, 5'd3, 13'h0));
        prog.push_back(enc(issue_pkg::OP_ADDI, 5'd6, 5'd4, 5'd0, 13'h1021));
        prog.push_back(enc(issue_pkg::OP_OR, 5'd7, 5'd6, 5'd4, 13'h0));
        prog.push_back(enc(issue_pkg::OP_AND, 5'd7, 5'd7, 5'd2, 13'h0));
        prog.push_back(enc(issue_pkg::OP_XOR, 5'd8, 5'd1, 5'd7, 13'h0));
        run_prog(0);
    endtask

    // distance 1, 2 and 3 cover execute, write-back and register file reads
    task automatic forward_chain();
        for (int i = 0; i < 12; i++) begin
            prog.push_back(enc(issue_pkg::OP_ADD, 5'(i % 6 + 1), 5'((i + 5) % 6 + 1),
                               5'((i + 3 + i % 2) % 6 + 1), 13'h0));
        end
        run_prog(0);
    endtask

    task automatic x0_and_nop();
        prog.push_back(enc(issue_pkg::OP_ADD, 5'd7, 5'd0, 5'd0, 13'h0));
        prog.push_back(enc(issue_pkg::OP_ADDI, 5'd0, 5'd5, 5'd0, 13'h7));
        prog.push_back(enc(4'hc, 5'd8, 5'd1, 5'd2, 13'h55));
        prog.push_back(enc(issue_pkg::OP_OR, 5'd9, 5'd8, 5'd0, 13'h0));
        prog.push_back(enc(issue_pkg::OP_LUI, 5'd10, 5'd0, 5'd0, 13'h1abc));
        prog.push_back(enc(issue_pkg::OP_SUB, 5'd11, 5'd0, 5'd7, 13'h0));
        run_prog(0);
    endtask

    task automatic pause_and_flush();
        logic [1:0]  iss;
        logic [31:0] wa;
        logic [31:0] wb_word;
        wa      = enc(issue_pkg::OP_ADD, 5'd14, 5'd12, 5'd13, 13'h0);
        wb_word = enc(issue_pkg::OP_SUB, 5'd15, 5'd13, 5'd12, 13'h0);
        offer(enc(issue_pkg::OP_ADDI, 5'd12, 5'd12, 5'd0, 13'h64), 1'b1,
              enc(issue_pkg::OP_ADDI, 5'd13, 5'd13, 5'd0, 13'hc8), 1'b1, 1'b0, 1'b0, iss);
        for (int i = 0; i < 2; i++) begin
            offer(wa, 1'b1, wb_word, 1'b1, 1'b1, 1'b0, iss);
            check(iss, 2'b00, "issued_o under pause");
        end
        offer(wa, 1'b1, wb_word, 1'b1, 1'b0, 1'b0, iss);
        wa      = enc(issue_pkg::OP_ADD, 5'd16, 5'd12, 5'd13, 13'h0);
        wb_word = enc(issue_pkg::OP_XOR, 5'd17, 5'd12, 5'd13, 13'h0);
        offer(enc(issue_pkg::OP_ADDI, 5'd12, 5'd12, 5'd0, 13'h1f00), 1'b1,
              enc(issue_pkg::OP_LUI, 5'd13, 5'd0, 5'd0, 13'h0ff), 1'b1, 1'b0, 1'b0, iss);
        offer(wa, 1'b1, wb_word, 1'b1, 1'b0, 1'b1, iss);
        check(iss, 2'b00, "issued_o under flush");
        offer(wa, 1'b1, wb_word, 1'b1, 1'b0, 1'b0, iss);
        drain();
    endtask

    task automatic random_stream();
        for (int i = 0; i < 400; i++) begin
            prog.push_back($random(seed));
        end
        run_prog(10);
    endtask

    // wb_o is registered, so the falling edge sees it settled
    always @(negedge clk) begin
        if (rst_n_i) begin
            for (int s = 0; s < 2; s++) begin
                if (wb[s].we && exp_q.size() == 0) begin
                    abort_run($sformatf("write-back to x%0d at %0t when no result was expected",
                                        wb[s].rd, $time));
                end else if (wb[s].we) begin
                    head = exp_q.pop_front();
                    check(wb[s].rd, head.rd, "wb_o rd");
                    check(wb[s].data, head.data, "wb_o data");
                    check(cyc_cnt, head.cyc, "write-back cycle");
                end
            end
        end
    end

    initial begin
        repeat (N_INSTR * 4 + 200) @(posedge clk);
        abort_run("timeout: the tests did not finish within the expected number of cycles");
    end

    initial begin
        seed         = 32'hbf43_fe48;
        rst_n_i      = 1'b0;
        pause_i      = 1'b0;
        flush_i      = 1'b0;
        inst_i       = '0;
        inst_valid_i = '0;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        check(issued_o, 32'd0, "issued_o in reset");
        check({wb[1].we, wb[0].we}, 32'd0, "wb_o write enables in reset");
        rst_n_i = 1'b1;
        init_regs();
        pair_issue();
        split_dependent();
        forward_chain();
        x0_and_nop();
        pause_and_flush();
        random_stream();
        drain();
        if (exp_q.size() != 0) begin
            abort_run("expected write-back results were still pending at the end");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

/* issue_core.f */
design/issue_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/dual_dispatch.sv
design/exec_unit.sv
design/issue_core.sv
sim/issue_core_tb.sv

/* Bender.yml */
package:
  name: issue_core

sources:
  - files:
      - design/issue_pkg.sv
      - design/inst_decoder.sv
      - design/reg_file.sv
      - design/dual_dispatch.sv
      - design/exec_unit.sv
      - design/issue_core.sv
  - target: simulation
    files:
      - sim/issue_core_tb.sv
